// File: project.f
+incdir+rtl
rtl/hack_isa_pkg.sv
rtl/hack_cpu_pkg.sv
rtl/hack_alu.sv
rtl/cycle_control.sv
rtl/program_counter.sv
rtl/inst_decoder.sv
rtl/reg_datapath.sv
rtl/hack_cpu.sv
testbench/tb_clock.sv
testbench/hack_cpu_tb.sv

// File: rtl/cycle_control.sv
module cycle_control
(
    input  logic clk,
    input  logic resetN,
    output logic inst_load,
    output logic exec_en
);

    import hack_cpu_pkg::*;

    cycle_state_e state;
    cycle_state_e next_state;

    // fixed rotation, each instruction costs exactly three cycles
    always_comb
    begin
        case (state)
            FETCH:   next_state = DECODE;
            DECODE:  next_state = EXECUTE;
            EXECUTE: next_state = FETCH;
            // the spare code falls back to a clean fetch
            default: next_state = FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            state <= FETCH;
        end
        else
        begin
            state <= next_state;
        end
    end

    // ROM data is on in_inst during DECODE, so the IR loads then
    assign inst_load = (state == DECODE);
    // registers, pc and the RAM write all act in EXECUTE
    assign exec_en = (state == EXECUTE);

    // the register must never drift into the spare code
    assert property (@(posedge clk) disable iff (!resetN)
        state != cycle_state_e'(2'b11));

    // decode is always followed by exactly one execute cycle, never overlapping it
    assert property (@(posedge clk) disable iff (!resetN)
        inst_load |-> !exec_en ##1 (exec_en && !inst_load));

endmodule

// File: rtl/hack_alu.sv
`include "hack_config.svh"

module hack_alu
(
    input  logic [`HACK_DATA_WIDTH-1:0]  x,
    input  logic [`HACK_DATA_WIDTH-1:0]  y,
    input  hack_isa_pkg::alu_fn_e        fn,
    output logic [`HACK_DATA_WIDTH-1:0]  result,
    output hack_cpu_pkg::alu_flags_t     flags
);

    logic [5:0]                   ctl;
    logic [`HACK_DATA_WIDTH-1:0]  x_z;
    logic [`HACK_DATA_WIDTH-1:0]  x_n;
    logic [`HACK_DATA_WIDTH-1:0]  y_z;
    logic [`HACK_DATA_WIDTH-1:0]  y_n;
    logic [`HACK_DATA_WIDTH-1:0]  f_out;

    // control bits as raw wires, so any 6-bit code works
    assign ctl = fn;

    // zero first, then invert, on each operand
    assign x_z = ctl[5] ? '0 : x;
    assign x_n = ctl[4] ? ~x_z : x_z;
    assign y_z = ctl[3] ? '0 : y;
    assign y_n = ctl[2] ? ~y_z : y_z;

    // sum wraps modulo 2^16, the carry out is dropped
    assign f_out  = ctl[1] ? (x_n + y_n) : (x_n & y_n);
    assign result = ctl[0] ? ~f_out : f_out;

    assign flags.zero = (result == '0);
    assign flags.neg  = result[`HACK_DATA_WIDTH-1];

endmodule

// File: rtl/hack_config.svh
`ifndef HACK_CONFIG_SVH
`define HACK_CONFIG_SVH

// ********************************************************************
// machine widths shared by every block
// ********************************************************************

// one data word, also the width of A, D and the ALU
`define HACK_DATA_WIDTH 16

// ROM and RAM word address, which is the low part of A
`define HACK_ADDR_WIDTH 15

`endif

// File: rtl/hack_cpu.sv
`include "hack_config.svh"

module hack_cpu
(
    input  logic                         clk,
    input  logic                         resetN,
    // ROM port, in_inst follows inst_addr by one cycle
    output logic [`HACK_ADDR_WIDTH-1:0]  inst_addr,
    input  logic [`HACK_DATA_WIDTH-1:0]  in_inst,
    // RAM read port, in_m follows read_addr by one cycle
    output logic [`HACK_ADDR_WIDTH-1:0]  read_addr,
    input  logic [`HACK_DATA_WIDTH-1:0]  in_m,
    output hack_cpu_pkg::ram_wr_t        ram_wr
);

    import hack_isa_pkg::*;
    import hack_cpu_pkg::*;

    logic                         inst_load;
    logic                         exec_en;
    decoded_t                     dec;
    logic [`HACK_DATA_WIDTH-1:0]  a_value;
    alu_flags_t                   flags;

    // ********************************************************************
    // sequencer, fetch and decode
    // ********************************************************************

    cycle_control cycle_control_i
    (
        .clk       (clk),
        .resetN    (resetN),
        .inst_load (inst_load),
        .exec_en   (exec_en)
    );

    program_counter program_counter_i
    (
        .clk       (clk),
        .resetN    (resetN),
        .exec_en   (exec_en),
        .dec       (dec),
        .flags     (flags),
        .a_value   (a_value),
        .inst_addr (inst_addr)
    );

    inst_decoder inst_decoder_i
    (
        .clk       (clk),
        .inst_load (inst_load),
        .in_inst   (in_inst),
        .dec       (dec)
    );

    // ********************************************************************
    // registers and ALU
    // ********************************************************************

    reg_datapath reg_datapath_i
    (
        .clk     (clk),
        .resetN  (resetN),
        .exec_en (exec_en),
        .dec     (dec),
        .in_m    (in_m),
        .a_value (a_value),
        .flags   (flags),
        .ram_wr  (ram_wr)
    );

    // the RAM is always addressed by A, so in_m tracks M without a request
    assign read_addr = a_value[`HACK_ADDR_WIDTH-1:0];

endmodule

// File: rtl/hack_cpu_pkg.sv
`include "hack_config.svh"

package hack_cpu_pkg;

    // one instruction walks through these three states in order
    // the fourth code of the register is never entered
    typedef enum logic [1:0]
    {
        FETCH   = 2'd0,
        DECODE  = 2'd1,
        EXECUTE = 2'd2
    } cycle_state_e;

    // ALU result status, positive is derived as neither of the two
    typedef struct packed
    {
        logic zero;
        logic neg;
    } alu_flags_t;

    // RAM write port, the RAM stores data at addr on each edge with en high
    typedef struct packed
    {
        logic                         en;
        logic [`HACK_ADDR_WIDTH-1:0]  addr;
        logic [`HACK_DATA_WIDTH-1:0]  data;
    } ram_wr_t;

endpackage

// File: rtl/hack_isa_pkg.sv
`include "hack_config.svh"

package hack_isa_pkg;

    // the six ALU control bits of a compute instruction, in the order
    // zx nx zy ny f no, where X is D and Y is A or memory
    typedef enum logic [5:0]
    {
        X_AND_Y   = 6'b000000,
        X_PLUS_Y  = 6'b000010,
        Y_MINUS_X = 6'b000111,
        X         = 6'b001100,
        NOT_X     = 6'b001101,
        X_MINUS_1 = 6'b001110,
        NEG_X     = 6'b001111,
        X_MINUS_Y = 6'b010011,
        X_OR_Y    = 6'b010101,
        X_PLUS_1  = 6'b011111,
        ZERO      = 6'b101010,
        Y         = 6'b110000,
        NOT_Y     = 6'b110001,
        Y_MINUS_1 = 6'b110010,
        NEG_Y     = 6'b110011,
        Y_PLUS_1  = 6'b110111,
        MINUS_ONE = 6'b111010,
        ONE       = 6'b111111
    } alu_fn_e;

    // jump bits are lt, eq, gt from msb to lsb, so the code is the mask
    typedef enum logic [2:0]
    {
        JNONE = 3'b000,
        JGT   = 3'b001,
        JEQ   = 3'b010,
        JGE   = 3'b011,
        JLT   = 3'b100,
        JNE   = 3'b101,
        JLE   = 3'b110,
        JMP   = 3'b111
    } jump_cond_e;

    // everything the execute cycle needs from one instruction word
    typedef struct packed
    {
        logic                         is_addr_inst;
        logic [`HACK_ADDR_WIDTH-1:0]  immediate;
        logic                         sel_m;
        alu_fn_e                      alu_fn;
        logic                         load_a;
        logic                         load_d;
        logic                         load_m;
        jump_cond_e                   jump;
    } decoded_t;

endpackage

// File: rtl/inst_decoder.sv
`include "hack_config.svh"

module inst_decoder
(
    input  logic                         clk,
    input  logic                         inst_load,
    input  logic [`HACK_DATA_WIDTH-1:0]  in_inst,
    output hack_isa_pkg::decoded_t       dec
);

    import hack_isa_pkg::*;

    logic [`HACK_DATA_WIDTH-1:0] ir;
    logic                        is_addr;

    // instruction register, loaded once per instruction at the end of DECODE
    always_ff @(posedge clk)
    begin
        if (inst_load)
            ir <= in_inst;
    end

    // ********************************************************************
    // field split
    // ********************************************************************

    // bit 15 clear marks an address instruction
    assign is_addr = !ir[15];

    always_comb
    begin
        dec.is_addr_inst = is_addr;
        // only meaningful for an address instruction, A takes it as is
        dec.immediate    = ir[`HACK_ADDR_WIDTH-1:0];
        // a bit selects memory in place of A as the Y operand
        dec.sel_m        = ir[12];
        // codes outside the named set still run through the bit rule
        dec.alu_fn       = alu_fn_e'(ir[11:6]);
        // destinations and jump bits exist only in a compute instruction
        dec.load_a       = !is_addr && ir[5];
        dec.load_d       = !is_addr && ir[4];
        dec.load_m       = !is_addr && ir[3];
        dec.jump         = is_addr ? JNONE : jump_cond_e'(ir[2:0]);
    end

endmodule

// File: rtl/program_counter.sv
`include "hack_config.svh"

module program_counter
(
    input  logic                         clk,
    input  logic                         resetN,
    input  logic                         exec_en,
    input  hack_isa_pkg::decoded_t       dec,
    input  hack_cpu_pkg::alu_flags_t     flags,
    input  logic [`HACK_DATA_WIDTH-1:0]  a_value,
    output logic [`HACK_ADDR_WIDTH-1:0]  inst_addr
);

    import hack_isa_pkg::*;

    logic is_pos;
    logic jump_taken;

    assign is_pos = !flags.zero && !flags.neg;

    // an address instruction never jumps, the decoder already forces JNONE
    // but the check here keeps the pc safe on its own
    always_comb
    begin
        jump_taken = 1'b0;
        if (!dec.is_addr_inst)
        begin
            case (dec.jump)
                JGT:     jump_taken = is_pos;
                JEQ:     jump_taken = flags.zero;
                JGE:     jump_taken = !flags.neg;
                JLT:     jump_taken = flags.neg;
                JNE:     jump_taken = !flags.zero;
                JLE:     jump_taken = !is_pos;
                JMP:     jump_taken = 1'b1;
                default: jump_taken = 1'b0;
            endcase
        end
    end

    // target is A's low bits, otherwise step by one and wrap at 15 bits
    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            inst_addr <= '0;
        end
        else if (exec_en)
        begin
            if (jump_taken)
                inst_addr <= a_value[`HACK_ADDR_WIDTH-1:0];
            else
                inst_addr <= inst_addr + 1'b1;
        end
    end

    // the ROM sees one address for the whole fetch and decode of an instruction
    assert property (@(posedge clk) disable iff (!resetN)
        !exec_en |=> $stable(inst_addr));

endmodule

// File: rtl/reg_datapath.sv
`include "hack_config.svh"

module reg_datapath
(
    input  logic                         clk,
    input  logic                         resetN,
    input  logic                         exec_en,
    input  hack_isa_pkg::decoded_t       dec,
    input  logic [`HACK_DATA_WIDTH-1:0]  in_m,
    output logic [`HACK_DATA_WIDTH-1:0]  a_value,
    output hack_cpu_pkg::alu_flags_t     flags,
    output hack_cpu_pkg::ram_wr_t        ram_wr
);

    logic [`HACK_DATA_WIDTH-1:0] a_reg;
    logic [`HACK_DATA_WIDTH-1:0] d_reg;
    logic [`HACK_DATA_WIDTH-1:0] y_in;
    logic [`HACK_DATA_WIDTH-1:0] alu_result;

    // in_m is valid in EXECUTE since A has not moved since the last EXECUTE
    assign y_in = dec.sel_m ? in_m : a_reg;

    hack_alu hack_alu_i
    (
        .x      (d_reg),
        .y      (y_in),
        .fn     (dec.alu_fn),
        .result (alu_result),
        .flags  (flags)
    );

    // ********************************************************************
    // A and D update at the end of EXECUTE
    // ********************************************************************

    always_ff @(posedge clk or negedge resetN)
    begin
        if (!resetN)
        begin
            a_reg <= '0;
            d_reg <= '0;
        end
        else if (exec_en)
        begin
            // immediate has its top bit clear by construction
            if (dec.is_addr_inst)
                a_reg <= {1'b0, dec.immediate};
            else if (dec.load_a)
                a_reg <= alu_result;
            if (dec.load_d)
                d_reg <= alu_result;
        end
    end

    assign a_value = a_reg;

    // the write uses the old A, so M=... lands where A pointed before the edge
    assign ram_wr.en   = exec_en && dec.load_m;
    assign ram_wr.addr = a_reg[`HACK_ADDR_WIDTH-1:0];
    assign ram_wr.data = alu_result;

    // a write only happens in EXECUTE, with an address held since the cycle before
    assert property (@(posedge clk) disable iff (!resetN)
        ram_wr.en |-> exec_en && $stable(ram_wr.addr));

endmodule

// File: run_sim.sh
#!/bin/sh
# build the RTL and the testbench into one Verilator binary, then run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module hack_cpu_tb
if [ $? -ne 0 ]
then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vhack_cpu_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]
then
    echo "simulation exited with status $status"
    exit 1
fi

# the verdict is the pass line that the testbench prints at the end
if echo "$output" | grep -qx "Everything OK"
then
    exit 0
fi
echo "pass line not found in the simulation output"
exit 1

// File: testbench/hack_cpu_tb.sv
`include "hack_config.svh"

module hack_cpu_tb;

    import hack_isa_pkg::*;
    import hack_cpu_pkg::*;

    localparam int DW         = `HACK_DATA_WIDTH;
    localparam int AW         = `HACK_ADDR_WIDTH;
    localparam int MEM_DEPTH  = 1 << AW;
    localparam int WAIT_LIMIT = 32;
    // destination bits of a compute instruction, A D M from msb to lsb
    localparam logic [2:0] DEST_NONE = 3'b000;
    localparam logic [2:0] DEST_M    = 3'b001;
    localparam logic [2:0] DEST_D    = 3'b010;
    localparam logic [2:0] DEST_A    = 3'b100;
    localparam logic [AW-1:0] JUMP_TARGET = 15'd20;

    logic            clk;
    logic            resetN = 1'b0;
    logic [AW-1:0]   inst_addr;
    logic [DW-1:0]   in_inst = '0;
    logic [AW-1:0]   read_addr;
    logic [DW-1:0]   in_m = '0;
    ram_wr_t         ram_wr;
    logic [DW-1:0]   rom [0:MEM_DEPTH-1];
    logic [DW-1:0]   ram [0:MEM_DEPTH-1];
    // RAM presets go through the memory process, one word per cycle
    logic            preset_en = 1'b0;
    logic [AW-1:0]   preset_addr = '0;
    logic [DW-1:0]   preset_data = '0;
    logic [31:0]     lfsr = 32'hbbb47cdf;
    string           test_name;
    int              errors = 0;
    int              errors_at_start;
    int              tests_run = 0;
    int              tests_failed = 0;

    tb_clock tb_clock_i
    (
        .clk (clk)
    );

    hack_cpu dut_i
    (
        .clk       (clk),
        .resetN    (resetN),
        .inst_addr (inst_addr),
        .in_inst   (in_inst),
        .read_addr (read_addr),
        .in_m      (in_m),
        .ram_wr    (ram_wr)
    );

    // ********************************************************************
    // memory models, both answer one cycle after their address
    // ********************************************************************

    always @(posedge clk)
    begin
        in_inst <= rom[inst_addr];
        in_m    <= ram[read_addr];
        if (preset_en)
            ram[preset_addr] <= preset_data;
        else if (ram_wr.en)
            ram[ram_wr.addr] <= ram_wr.data;
    end

    // ********************************************************************
    // stimulus helpers
    // ********************************************************************

    // 32-bit Fibonacci LFSR with taps 32 22 2 1, one step per bit taken
    function automatic logic [DW-1:0] next_bits(input int n);
        logic [DW-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[DW-2:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [AW-1:0] next_addr();
        logic [DW-1:0] v;
        v = next_bits(AW);
        return v[AW-1:0];
    endfunction

    // address instruction, bit 15 clear and a 15-bit constant
    function automatic logic [DW-1:0] addr_inst(input logic [AW-1:0] v);
        return {1'b0, v};
    endfunction

    // compute instruction, 111 a cccccc ddd jjj
    function automatic logic [DW-1:0] comp_inst(input logic sel_m, input alu_fn_e fn,
                                                input logic [2:0] dest, input jump_cond_e j);
        return {3'b111, sel_m, fn, dest, j};
    endfunction

    // zero then invert each operand, add or and, then invert the result
    function automatic logic [DW-1:0] expected_alu(input logic [5:0] c,
                                                   input logic [DW-1:0] x, input logic [DW-1:0] y);
        logic [DW-1:0] xv;
        logic [DW-1:0] yv;
        logic [DW-1:0] r;
        xv = c[5] ? '0 : x;
        xv = c[4] ? ~xv : xv;
        yv = c[3] ? '0 : y;
        yv = c[2] ? ~yv : yv;
        r  = c[1] ? xv + yv : xv & yv;
        return c[0] ? ~r : r;
    endfunction

    function automatic ram_wr_t write_of(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        ram_wr_t w;
        w.en   = 1'b1;
        w.addr = addr;
        w.data = data;
        return w;
    endfunction

    // ********************************************************************
    // checks, one per kind of result
    // ********************************************************************

    task automatic check_word(input string name, input logic [DW-1:0] got,
                              input logic [DW-1:0] exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t in %s: %s got %h expected %h", $time, test_name, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [AW-1:0] got,
                              input logic [AW-1:0] exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t in %s: %s got %h expected %h", $time, test_name, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_ram_wr(input string name, input ram_wr_t got, input ram_wr_t exp);
        if (got !== exp)
        begin
            $display("ERROR at %0t in %s: %s got en=%b addr=%h data=%h expected en=%b addr=%h data=%h",
                     $time, test_name, name, got.en, got.addr, got.data,
                     exp.en, exp.addr, exp.data);
            errors++;
        end
    endtask

    // ********************************************************************
    // reset and wait tasks
    // ********************************************************************

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors == errors_at_start)
        begin
            $display("test %s passed", test_name);
        end
        else
        begin
            $display("test %s failed with %0d errors", test_name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    // reset goes low first so that the old program cannot write any more,
    // then the ROM gets "@address" at each word, a harmless filler
    task automatic hold_reset();
        @(posedge clk);
        resetN <= 1'b0;
        for (int i = 0; i < MEM_DEPTH; i++)
            rom[i] = {1'b0, i[AW-1:0]};
    endtask

    task automatic preset_ram(input logic [AW-1:0] addr, input logic [DW-1:0] data);
        @(negedge clk);
        preset_addr = addr;
        preset_data = data;
        preset_en   = 1'b1;
        @(negedge clk);
        preset_en   = 1'b0;
    endtask

    // four reset cycles with the outputs held quiet, then release on an edge
    task automatic release_reset();
        repeat (4)
        begin
            @(negedge clk);
            check_word("ram_wr.en", DW'(ram_wr.en), '0);
            check_addr("inst_addr", inst_addr, '0);
        end
        @(posedge clk);
        resetN <= 1'b1;
    endtask

    // returns at the negedge inside the EXECUTE cycle of the next RAM write
    task automatic wait_write(output ram_wr_t w);
        int n;
        n = 0;
        @(negedge clk);
        while (!ram_wr.en && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (!ram_wr.en)
        begin
            $display("test %s timed out waiting for a RAM write", test_name);
            errors++;
        end
        w = ram_wr;
    endtask

    // the fetch address that follows the instruction at addr
    task automatic wait_pc_leaves(input logic [AW-1:0] addr, output logic [AW-1:0] next);
        int n;
        n = 0;
        @(negedge clk);
        while (inst_addr != addr && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (inst_addr != addr)
        begin
            $display("test %s timed out before the pc reached %0d", test_name, addr);
            errors++;
        end
        n = 0;
        while (inst_addr == addr && n < WAIT_LIMIT)
        begin
            @(negedge clk);
            n++;
        end
        if (inst_addr == addr)
        begin
            $display("test %s timed out with the pc stuck at %0d", test_name, addr);
            errors++;
        end
        next = inst_addr;
    endtask

    // ********************************************************************
    // directed tests
    // ********************************************************************

    task automatic test_reset();
        begin_test("reset");
        hold_reset();
        rom[0] = addr_inst(15'd5);
        rom[1] = addr_inst(15'd7);
        release_reset();
        // cycle 0 is the first FETCH after release
        @(negedge clk);
        check_word("ram_wr.en", DW'(ram_wr.en), '0);
        check_addr("inst_addr", inst_addr, '0);
        // three cycles per instruction, so cycle 5 still fetches word 1
        repeat (5) @(negedge clk);
        check_addr("inst_addr", inst_addr, 15'd1);
        @(negedge clk);
        check_addr("inst_addr", inst_addr, 15'd2);
        end_test();
    endtask

    task automatic test_store();
        logic [AW-1:0] k;
        logic [AW-1:0] a;
        ram_wr_t       w;
        begin_test("constant store");
        k = next_addr();
        a = next_addr();
        hold_reset();
        rom[0] = addr_inst(k);
        rom[1] = comp_inst(1'b0, Y, DEST_D, JNONE);
        rom[2] = addr_inst(a);
        rom[3] = comp_inst(1'b0, X, DEST_M, JNONE);
        release_reset();
        wait_write(w);
        check_ram_wr("ram_wr", w, write_of(a, {1'b0, k}));
        end_test();
    endtask

    // X and Y come from RAM so that all 16 bits can be random
    task automatic test_alu();
        alu_fn_e       fn;
        logic [AW-1:0] ax;
        logic [AW-1:0] ay;
        logic [DW-1:0] x;
        logic [DW-1:0] y;
        ram_wr_t       w;
        begin_test("alu");
        fn = fn.first();
        do
        begin
            ax = next_addr();
            ay = ax + 15'd1;
            x  = next_bits(DW);
            y  = next_bits(DW);
            hold_reset();
            preset_ram(ax, x);
            preset_ram(ay, y);
            rom[0] = addr_inst(ax);
            rom[1] = comp_inst(1'b1, Y, DEST_D, JNONE);
            rom[2] = addr_inst(ay);
            rom[3] = comp_inst(1'b1, fn, DEST_M, JNONE);
            release_reset();
            wait_write(w);
            check_ram_wr(fn.name(), w, write_of(ay, expected_alu(fn, x, y)));
            fn = fn.next();
        end
        while (fn != fn.first());
        end_test();
    endtask

    task automatic test_mem_operand();
        logic [AW-1:0] a;
        logic [AW-1:0] b;
        logic [DW-1:0] v;
        ram_wr_t       w;
        begin_test("memory operand");
        a = next_addr();
        b = a ^ 15'h4000;
        v = next_bits(DW);
        hold_reset();
        preset_ram(a, v);
        rom[0] = addr_inst(a);
        rom[1] = comp_inst(1'b1, Y, DEST_D, JNONE);
        rom[2] = addr_inst(b);
        rom[3] = comp_inst(1'b0, X, DEST_M, JNONE);
        rom[4] = addr_inst(a);
        rom[5] = comp_inst(1'b1, Y_PLUS_1, DEST_M, JNONE);
        release_reset();
        wait_write(w);
        check_ram_wr("ram_wr", w, write_of(b, v));
        wait_write(w);
        check_ram_wr("ram_wr", w, write_of(a, v + 16'd1));
        end_test();
    endtask

    // sign 0 is negative, 1 is zero and 2 is positive
    task automatic test_jumps();
        logic [2:0]    jb;
        logic [AW-1:0] k;
        logic [AW-1:0] next;
        logic          taken;
        begin_test("jumps");
        for (int j = 0; j < 8; j++)
        begin
            for (int s = 0; s < 3; s++)
            begin
                jb = 3'(j);
                k  = next_addr() | 15'd1;
                hold_reset();
                rom[0] = addr_inst(k);
                if (s == 0)
                    rom[1] = comp_inst(1'b0, NEG_Y, DEST_D, JNONE);
                else if (s == 1)
                    rom[1] = comp_inst(1'b0, ZERO, DEST_D, JNONE);
                else
                    rom[1] = comp_inst(1'b0, Y, DEST_D, JNONE);
                rom[2] = addr_inst(JUMP_TARGET);
                rom[3] = comp_inst(1'b0, X, DEST_NONE, jump_cond_e'(jb));
                release_reset();
                wait_pc_leaves(15'd3, next);
                // jump bits are lt eq gt, taken when the bit of the sign is set
                taken = (s == 0 && jb[2]) || (s == 1 && jb[1]) || (s == 2 && jb[0]);
                check_addr("inst_addr", next, taken ? JUMP_TARGET : 15'd4);
            end
        end
        end_test();
    endtask

    task automatic test_a_dest();
        logic [AW-1:0] k;
        ram_wr_t       w;
        begin_test("A as destination");
        // 14 random bits keep k+1 inside the address range
        k = 15'(next_bits(AW - 1));
        hold_reset();
        rom[0] = addr_inst(k);
        rom[1] = comp_inst(1'b0, Y, DEST_D, JNONE);
        rom[2] = comp_inst(1'b0, X_PLUS_1, DEST_A, JNONE);
        rom[3] = comp_inst(1'b0, X, DEST_M, JNONE);
        release_reset();
        wait_write(w);
        check_ram_wr("ram_wr", w, write_of(k + 15'd1, {1'b0, k}));
        check_addr("read_addr", read_addr, k + 15'd1);
        end_test();
    endtask

    initial
    begin
        test_reset();
        test_store();
        test_alu();
        test_mem_operand();
        test_jumps();
        test_a_dest();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
module tb_clock
#(
    parameter int HALF_PERIOD = 20
)
(
    output logic clk
);

    // free running clock, the period is two half periods
    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

endmodule
